// ==== design/md_pkg.sv ====
package md_pkg;

    // operation codes as seen on the issue port
    typedef enum logic [1:0] {
        OP_MULT  = 2'd0,
        OP_MULTU = 2'd1,
        OP_DIV   = 2'd2,
        OP_DIVU  = 2'd3
    } md_op_e;

    // one issued operation
    typedef struct packed {
        md_op_e      op;
        // multiplicand or dividend
        logic [31:0] src1;
        // multiplier or divisor
        logic [31:0] src2;
    } md_cmd_t;

    // hi/lo pair returned to the pipeline
    typedef struct packed {
        // product high half or remainder
        logic [31:0] hi;
        // product low half or quotient
        logic [31:0] lo;
    } md_res_t;

    // lane count and lane index width
    localparam int NUM_LANES = 4;
    localparam int LANE_W = 2;

    // cycles from start to done including conditioning, 32 iterations and fix-up
    localparam int LANE_CYCLES = 34;

endpackage

// ==== design/md_dispatch.sv ====
`timescale 1ns/1ps

module md_dispatch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          up_req,
    input  md_pkg::md_cmd_t               up_cmd,
    output logic                          up_ack,
    input  logic [md_pkg::NUM_LANES-1:0]  lane_busy,
    output logic [md_pkg::NUM_LANES-1:0]  lane_start,
    output md_pkg::md_cmd_t               lane_cmd
);
    import md_pkg::*;

    // round-robin issue pointer
    logic [LANE_W-1:0] ptr;
    logic              accept;

    // new request, previous handshake closed, and the lane in turn is free
    assign accept = up_req && !up_ack && !lane_busy[ptr];

    // one-hot decode of the pointer, only in the accepting cycle
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_start[i] = accept && (ptr == LANE_W'(i));
        end
    end

    // the requester holds up_cmd while up_req is high and the lane captures it on start
    assign lane_cmd = up_cmd;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (accept) begin
            if (ptr == LANE_W'(NUM_LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + LANE_W'(1);
            end
        end
    end

    // four-phase issue handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            up_ack <= 1'b0;
        end else if (accept) begin
            up_ack <= 1'b1;
        end else if (up_ack && !up_req) begin
            up_ack <= 1'b0;
        end
    end

    // a waiting request keeps its command until up_ack answers
    a_req_stable : assert property (
        @(posedge clk) disable iff (rst)
        up_req && !up_ack |=> up_req && $stable(up_cmd)
    );

endmodule

// ==== design/md_lane.sv ====
`timescale 1ns/1ps

module md_lane (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  md_pkg::md_cmd_t cmd,
    input  logic            take,
    output logic            busy,
    output logic            done,
    output md_pkg::md_res_t res
);
    import md_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,
        ST_FIX,
        ST_DONE
    } lane_state_e;

    lane_state_e state;
    logic [4:0]  cnt;

    // operand conditioning happens in the start cycle itself
    logic        is_signed;
    logic        is_div;
    logic        sgn1;
    logic        sgn2;
    logic [31:0] abs1;
    logic [31:0] abs2;

    // working registers
    logic        is_div_r;
    logic        neg_q;
    logic        neg_r;
    logic [31:0] opnd;
    logic [63:0] acc;

    // one iteration step for each kind
    logic [32:0] mul_sum;
    logic [32:0] div_diff;
    logic [63:0] prod_fix;

    assign is_signed = (cmd.op == OP_MULT) || (cmd.op == OP_DIV);
    assign is_div    = (cmd.op == OP_DIV) || (cmd.op == OP_DIVU);
    assign sgn1      = is_signed && cmd.src1[31];
    assign sgn2      = is_signed && cmd.src2[31];
    assign abs1      = sgn1 ? -cmd.src1 : cmd.src1;
    assign abs2      = sgn2 ? -cmd.src2 : cmd.src2;

    // add the multiplicand into the high half when the low bit is set
    assign mul_sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opnd} : 33'd0);
    // trial subtract of the divisor from the shifted partial remainder
    assign div_diff = acc[63:31] - {1'b0, opnd};
    assign prod_fix = neg_q ? -acc : acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_ITER;
                        cnt   <= '0;
                    end
                end
                ST_ITER: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31) begin
                        state <= ST_FIX;
                    end
                end
                ST_FIX: begin
                    state <= ST_DONE;
                end
                default: begin
                    // hold the result until the collector takes it
                    if (take) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            is_div_r <= is_div;
            opnd     <= is_div ? abs2 : abs1;
            acc      <= {32'd0, is_div ? abs1 : abs2};
            // a zero divisor keeps the all-ones quotient whatever the dividend sign
            neg_q    <= is_div ? ((sgn1 ^ sgn2) && (cmd.src2 != '0)) : (sgn1 ^ sgn2);
            // remainder follows the dividend
            neg_r    <= sgn1;
        end else if (state == ST_ITER) begin
            if (!is_div_r) begin
                acc <= {mul_sum, acc[31:1]};
            end else if (!div_diff[32]) begin
                acc <= {div_diff[31:0], acc[30:0], 1'b1};
            end else begin
                acc <= {acc[62:0], 1'b0};
            end
        end
    end

    // sign fix-up in the last cycle
    always_ff @(posedge clk) begin
        if (state == ST_FIX) begin
            if (is_div_r) begin
                res.hi <= neg_r ? -acc[63:32] : acc[63:32];
                res.lo <= neg_q ? -acc[31:0] : acc[31:0];
            end else begin
                res <= prod_fix;
            end
        end
    end

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_DONE);

    a_no_start_busy : assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    );

endmodule

// ==== design/md_collect.sv ====
`timescale 1ns/1ps

module md_collect (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [md_pkg::NUM_LANES-1:0]  lane_done,
    input  md_pkg::md_res_t               lane_res [md_pkg::NUM_LANES],
    output logic [md_pkg::NUM_LANES-1:0]  lane_take,
    output logic                          dn_req,
    input  logic                          dn_ack,
    output md_pkg::md_res_t               dn_res
);
    import md_pkg::*;

    // drain pointer follows the issue order
    logic [LANE_W-1:0] ptr;
    logic              out_free;
    logic              take_any;

    // output register is free once the previous handshake has fully closed
    assign out_free = !dn_req && !dn_ack;
    assign take_any = out_free && lane_done[ptr];

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_take[i] = take_any && (ptr == LANE_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (take_any) begin
            if (ptr == LANE_W'(NUM_LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + LANE_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_any) begin
            dn_res <= lane_res[ptr];
        end
    end

    // four-phase result handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            dn_req <= 1'b0;
        end else if (take_any) begin
            dn_req <= 1'b1;
        end else if (dn_req && dn_ack) begin
            dn_req <= 1'b0;
        end
    end

    // a finished lane waiting its turn keeps done and its result
    a_lane_hold : assert property (
        @(posedge clk) disable iff (rst)
        lane_done[ptr] && !take_any |=> lane_done[ptr] && $stable(lane_res[ptr])
    );

endmodule

// ==== design/md_unit.sv ====
`timescale 1ns/1ps

module md_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            up_req,
    input  md_pkg::md_cmd_t up_cmd,
    output logic            up_ack,
    output logic            dn_req,
    input  logic            dn_ack,
    output md_pkg::md_res_t dn_res
);
    import md_pkg::*;

    logic [NUM_LANES-1:0] lane_start;
    logic [NUM_LANES-1:0] lane_busy;
    logic [NUM_LANES-1:0] lane_done;
    logic [NUM_LANES-1:0] lane_take;
    md_cmd_t              lane_cmd;
    md_res_t              lane_res [NUM_LANES];

    md_dispatch i_md_dispatch (
        .clk        (clk),
        .rst        (rst),
        .up_req     (up_req),
        .up_cmd     (up_cmd),
        .up_ack     (up_ack),
        .lane_busy  (lane_busy),
        .lane_start (lane_start),
        .lane_cmd   (lane_cmd)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        md_lane i_md_lane (
            .clk   (clk),
            .rst   (rst),
            .start (lane_start[i]),
            .cmd   (lane_cmd),
            .take  (lane_take[i]),
            .busy  (lane_busy[i]),
            .done  (lane_done[i]),
            .res   (lane_res[i])
        );
    end

    md_collect i_md_collect (
        .clk       (clk),
        .rst       (rst),
        .lane_done (lane_done),
        .lane_res  (lane_res),
        .lane_take (lane_take),
        .dn_req    (dn_req),
        .dn_ack    (dn_ack),
        .dn_res    (dn_res)
    );

endmodule

// ==== test/md_unit_tb.sv ====
`timescale 1ns/1ps

module md_unit_tb;
    import md_pkg::*;

    localparam int TOTAL_OPS = 88;
    localparam int WATCHDOG_NS = TOTAL_OPS * (LANE_CYCLES + 20) * 4;

    logic    clk;
    logic    rst;
    logic    up_req;
    md_cmd_t up_cmd;
    logic    up_ack;
    logic    dn_req;
    logic    dn_ack;
    md_res_t dn_res;

    // commands in issue order that still wait for their results
    md_cmd_t sent_q[$];
    string   cur_test;
    int      n_sent;
    int      n_recv;
    int      n_pass;
    int      n_fail;
    int      test_sent0;
    int      test_fail0;
    int      req_rises;
    int      ack_rises;
    logic    up_req_q;
    logic    up_ack_q;
    logic    dn_req_q;

    logic [31:0] corners [4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

    md_unit i_md_unit (
        .clk    (clk),
        .rst    (rst),
        .up_req (up_req),
        .up_cmd (up_cmd),
        .up_ack (up_ack),
        .dn_req (dn_req),
        .dn_ack (dn_ack),
        .dn_res (dn_res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected hi/lo worked out with 64-bit arithmetic
    function automatic md_res_t md_model(input md_cmd_t c);
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        p;
        logic [63:0]        q;
        logic [63:0]        r;
        ua = {32'd0, c.src1};
        ub = {32'd0, c.src2};
        sa = {{32{c.src1[31]}}, c.src1};
        sb = {{32{c.src2[31]}}, c.src2};
        p = '0;
        // a zero divisor gives an all-ones quotient and the dividend as remainder
        q = '1;
        r = ua;
        case (c.op)
            OP_MULTU: p = ua * ub;
            OP_MULT:  p = sa * sb;
            OP_DIVU: begin
                if (c.src2 != '0) begin
                    q = ua / ub;
                    r = ua % ub;
                end
            end
            default: begin
                // signed / and % truncate toward zero
                if (c.src2 != '0) begin
                    q = sa / sb;
                    r = sa % sb;
                end
            end
        endcase
        if (c.op == OP_MULT || c.op == OP_MULTU) begin
            return p;
        end
        return {r[31:0], q[31:0]};
    endfunction

    function automatic md_cmd_t make_cmd(input md_op_e op, input logic [31:0] a,
                                         input logic [31:0] b);
        md_cmd_t c;
        c.op   = op;
        c.src1 = a;
        c.src2 = b;
        return c;
    endfunction

    function automatic md_op_e rand_op();
        logic [1:0] sel;
        sel = 2'($urandom_range(3, 0));
        return md_op_e'(sel);
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    // four-phase issue of one command starting on a rising edge
    task automatic issue_op(input md_cmd_t c);
        sent_q.push_back(c);
        n_sent++;
        up_req <= 1'b1;
        up_cmd <= c;
        do @(posedge clk); while (!up_ack);
        up_req <= 1'b0;
        do @(posedge clk); while (up_ack);
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_sent0 = n_sent;
        test_fail0 = n_fail;
    endtask

    // wait until every issued command has come back
    task automatic end_test();
        while (n_recv != n_sent) @(posedge clk);
        $display("test %s: %0d ops, %0d errors", cur_test, n_sent - test_sent0,
                 n_fail - test_fail0);
    endtask

    initial begin
        logic [31:0] b;
        void'($urandom(93));
        rst    <= 1'b1;
        up_req <= 1'b0;
        up_cmd <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_idle");
        repeat (8) begin
            @(posedge clk);
            check_val("reset_idle up_ack", 64'd0, 64'(up_ack));
            check_val("reset_idle dn_req", 64'd0, 64'(dn_req));
        end
        end_test();

        start_test("mult_corner");
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                issue_op(make_cmd(OP_MULTU, corners[i], corners[j]));
                issue_op(make_cmd(OP_MULT, corners[i], corners[j]));
            end
        end
        end_test();

        start_test("mul_random");
        for (int i = 0; i < 8; i++) begin
            issue_op(make_cmd(OP_MULTU, $urandom, $urandom));
            issue_op(make_cmd(OP_MULT, $urandom, $urandom));
        end
        end_test();

        start_test("div_random");
        for (int i = 0; i < 8; i++) begin
            // smaller divisors keep the quotients interesting
            b = $urandom >> $urandom_range(28, 4);
            if (b == '0) begin
                b = 32'd3;
            end
            issue_op(make_cmd(OP_DIVU, $urandom, b));
            if ($urandom_range(1, 0) == 1) begin
                b = -b;
            end
            issue_op(make_cmd(OP_DIV, $urandom, b));
        end
        end_test();

        start_test("div_zero");
        issue_op(make_cmd(OP_DIV, 32'd12345, 32'd0));
        issue_op(make_cmd(OP_DIVU, 32'd12345, 32'd0));
        issue_op(make_cmd(OP_DIV, -32'd12345, 32'd0));
        issue_op(make_cmd(OP_DIVU, -32'd12345, 32'd0));
        issue_op(make_cmd(OP_DIV, 32'h8000_0000, 32'd0));
        issue_op(make_cmd(OP_DIVU, 32'h8000_0000, 32'd0));
        issue_op(make_cmd(OP_DIV, 32'd0, 32'd0));
        issue_op(make_cmd(OP_DIVU, 32'd0, 32'd0));
        end_test();

        // back to back issue keeps every lane in use
        start_test("burst");
        for (int i = 0; i < 16; i++) begin
            issue_op(make_cmd(rand_op(), $urandom, $urandom >> $urandom_range(24, 0)));
        end
        end_test();

        check_val("up_req/up_ack count", 64'(req_rises), 64'(ack_rises));
        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // sink with a random answer delay that compares each result in issue order
    initial begin
        int      delay;
        md_cmd_t c;
        dn_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (dn_req && !dn_ack) begin
                delay = $urandom_range(6, 0);
                repeat (delay) @(posedge clk);
                if (sent_q.size() == 0) begin
                    $display("ERROR: a result came back with no operation outstanding");
                    n_fail++;
                end else begin
                    c = sent_q.pop_front();
                    check_val(cur_test, md_model(c), dn_res);
                end
                n_recv++;
                dn_ack <= 1'b1;
                do @(posedge clk); while (dn_req);
                dn_ack <= 1'b0;
            end
        end
    end

    // handshake monitor
    always @(posedge clk) begin
        if (rst) begin
            up_req_q <= 1'b0;
            up_ack_q <= 1'b0;
            dn_req_q <= 1'b0;
        end else begin
            if (up_req && !up_req_q) begin
                req_rises++;
            end
            if (up_ack && !up_ack_q) begin
                ack_rises++;
            end
            if (dn_req && !dn_req_q && dn_ack) begin
                $display("ERROR: dn_req rose while dn_ack was still high");
                n_fail++;
            end
            up_req_q <= up_req;
            up_ack_q <= up_ack;
            dn_req_q <= dn_req;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: results did not come back within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== src.f ====
design/md_pkg.sv
design/md_dispatch.sv
design/md_lane.sv
design/md_collect.sv
design/md_unit.sv
test/md_unit_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module md_unit_tb -f src.f
	out="$$(./obj_dir/Vmd_unit_tb)"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
